// ==== Makefile ====
# Verilator build for the UDP receive core and its testbench

TOP := tb_udp_rx
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module udp_rx_core -f build.f
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f build.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
src/udp_rx_pkg.sv
src/rx_word_counter.sv
src/rx_header_capture.sv
src/rx_frame_fsm.sv
src/rx_payload_align.sv
src/udp_rx_core.sv
testbench/tb_udp_rx_check.sv
testbench/tb_udp_rx.sv

// ==== src/rx_frame_fsm.sv ====
/*
 * Frame FSM: walks each received frame through header, payload or drop
 * Produces the header strobe and the payload enables
 */
module rx_frame_fsm (
    input  logic                              clk,
    input  logic                              arst_n,
    input  udp_rx_pkg::eth_beat_t             rx,
    input  logic [udp_rx_pkg::WORD_IDX_W-1:0] word_idx,
    input  logic                              hdr_match,
    output logic                              hdr_valid,
    output logic                              load_tail,
    output logic                              pass_beat
);

    udp_rx_pkg::rx_state_e state;
    udp_rx_pkg::rx_state_e state_next;
    logic                  at_tail;

    // Beat 5 of a frame still in the header phase
    assign at_tail = rx.valid && (state == udp_rx_pkg::ST_HEADER)
                     && (word_idx == udp_rx_pkg::HDR_LAST_WORD);

    assign load_tail = at_tail && hdr_match;
    assign pass_beat = rx.valid && (state == udp_rx_pkg::ST_PAYLOAD);

    always_comb begin
        state_next = state;
        if (rx.valid) begin
            case (state)
                udp_rx_pkg::ST_IDLE: begin
                    state_next = udp_rx_pkg::ST_HEADER;
                end
                udp_rx_pkg::ST_HEADER: begin
                    // Accept decision once all checked fields are in
                    if (word_idx == udp_rx_pkg::HDR_LAST_WORD) begin
                        if (hdr_match) begin
                            state_next = udp_rx_pkg::ST_PAYLOAD;
                        end else begin
                            state_next = udp_rx_pkg::ST_DROP;
                        end
                    end
                end
                default: begin
                    state_next = state;
                end
            endcase
            // End of frame wins, a short frame just vanishes
            if (rx.last) begin
                state_next = udp_rx_pkg::ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= udp_rx_pkg::ST_IDLE;
            hdr_valid <= 1'b0;
        end else begin
            state     <= state_next;
            hdr_valid <= load_tail;
        end
    end

endmodule

// ==== src/rx_header_capture.sv ====
/*
 * Header capture: loads Ethernet, IPv4 and UDP fields from beats 1 to 4,
 * checks them against the accepted values and latches the UDP header bundle
 */
module rx_header_capture (
    input  logic                              clk,
    input  logic                              arst_n,
    input  udp_rx_pkg::eth_beat_t             rx,
    input  logic [udp_rx_pkg::WORD_IDX_W-1:0] word_idx,
    input  logic [31:0]                       local_ip,
    output udp_rx_pkg::udp_hdr_t              hdr,
    output logic                              hdr_match
);

    logic [15:0] eth_type;
    logic [7:0]  ver_ihl;
    logic [7:0]  ip_proto;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] udp_len;
    logic        take_hdr;

    // Fields are big-endian across lanes, lower lane is the high byte
    always_ff @(posedge clk) begin
        if (rx.valid) begin
            case (word_idx)
                3'd1: begin
                    // Bytes 12-14
                    eth_type <= {rx.data[39:32], rx.data[47:40]};
                    ver_ihl  <= rx.data[55:48];
                end
                3'd2: begin
                    // Byte 23
                    ip_proto <= rx.data[63:56];
                end
                3'd3: begin
                    // Bytes 26-31, dest IP upper half
                    src_ip        <= {rx.data[23:16], rx.data[31:24],
                                      rx.data[39:32], rx.data[47:40]};
                    dst_ip[31:16] <= {rx.data[55:48], rx.data[63:56]};
                end
                3'd4: begin
                    // Bytes 32-39
                    dst_ip[15:0] <= {rx.data[7:0], rx.data[15:8]};
                    src_port     <= {rx.data[23:16], rx.data[31:24]};
                    dst_port     <= {rx.data[39:32], rx.data[47:40]};
                    udp_len      <= {rx.data[55:48], rx.data[63:56]};
                end
                default: begin
                end
            endcase
        end
    end

    assign hdr_match = (eth_type == udp_rx_pkg::ETHERTYPE_IPV4)
                       && (ver_ihl == udp_rx_pkg::IP_VER_IHL)
                       && (ip_proto == udp_rx_pkg::IP_PROTO_UDP)
                       && (dst_ip == local_ip);

    // Bundle updates only for accepted frames
    assign take_hdr = rx.valid && (word_idx == udp_rx_pkg::HDR_LAST_WORD) && hdr_match;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdr <= '0;
        end else if (take_hdr) begin
            hdr.length      <= udp_len;
            hdr.dest_port   <= dst_port;
            hdr.source_port <= src_port;
            hdr.dest_ip     <= dst_ip;
            hdr.source_ip   <= src_ip;
        end
    end

endmodule

// ==== src/rx_payload_align.sv ====
/*
 * Payload realignment: shifts payload down by the header tail lanes,
 * merges held upper lanes with the next beat and flushes the remainder
 */
module rx_payload_align (
    input  logic                  clk,
    input  logic                  arst_n,
    input  udp_rx_pkg::eth_beat_t rx,
    input  logic                  load_tail,
    input  logic                  pass_beat,
    output udp_rx_pkg::eth_beat_t payload
);

    // Upper lanes of the previous beat
    logic [63-8*udp_rx_pkg::TAIL_BYTES:0] hold_data;
    logic [7-udp_rx_pkg::TAIL_BYTES:0]    hold_keep;
    logic                                 flush_pend;
    logic                                 upper_used;

    logic [63:0] out_data;
    logic [7:0]  out_keep;
    logic        out_valid;
    logic        out_last;

    // Final beat leaves bytes beyond the merge lanes
    assign upper_used = |rx.keep[7:udp_rx_pkg::TAIL_BYTES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            flush_pend <= 1'b0;
        end else begin
            out_valid <= pass_beat || flush_pend;
            out_last  <= flush_pend || (pass_beat && rx.last && !upper_used);
            if (load_tail || pass_beat) begin
                flush_pend <= rx.last && upper_used;
            end else begin
                flush_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_tail || pass_beat) begin
            hold_data <= rx.data[63:8*udp_rx_pkg::TAIL_BYTES];
            hold_keep <= rx.keep[7:udp_rx_pkg::TAIL_BYTES];
        end
        if (pass_beat) begin
            out_data <= {rx.data[8*udp_rx_pkg::TAIL_BYTES-1:0], hold_data};
            out_keep <= {rx.keep[udp_rx_pkg::TAIL_BYTES-1:0], hold_keep};
        end else if (flush_pend) begin
            // Leftover bytes only, top lanes empty
            out_data <= {{(8*udp_rx_pkg::TAIL_BYTES){1'b0}}, hold_data};
            out_keep <= {{udp_rx_pkg::TAIL_BYTES{1'b0}}, hold_keep};
        end
    end

    assign payload.data  = out_data;
    assign payload.keep  = out_keep;
    assign payload.valid = out_valid;
    assign payload.last  = out_last;

endmodule

// ==== src/rx_word_counter.sv ====
/*
 * Beat index within the current frame, saturating at 7
 */
module rx_word_counter (
    input  logic                              clk,
    input  logic                              arst_n,
    input  udp_rx_pkg::eth_beat_t             rx,
    output logic [udp_rx_pkg::WORD_IDX_W-1:0] word_idx
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_idx <= '0;
        end else if (rx.valid) begin
            if (rx.last) begin
                // Next beat starts a new frame
                word_idx <= '0;
            end else if (word_idx != '1) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

endmodule

// ==== src/udp_rx_core.sv ====
/*
 * UDP receive core: Ethernet II / IPv4 / UDP parser
 * Accepts frames for local_ip, emits header bundle and lane-0 aligned payload
 */
module udp_rx_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [31:0]           local_ip,
    input  udp_rx_pkg::eth_beat_t rx,
    output udp_rx_pkg::udp_hdr_t  hdr,
    output logic                  hdr_valid,
    output udp_rx_pkg::eth_beat_t payload
);

    logic [udp_rx_pkg::WORD_IDX_W-1:0] word_idx;
    logic                              hdr_match;
    logic                              load_tail;
    logic                              pass_beat;

    // Position of the current beat in its frame
    rx_word_counter word_counter0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .word_idx (word_idx)
    );

    // Field capture and address/protocol match
    rx_header_capture header_capture0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .word_idx  (word_idx),
        .local_ip  (local_ip),
        .hdr       (hdr),
        .hdr_match (hdr_match)
    );

    // Accept or drop decision per frame
    rx_frame_fsm frame_fsm0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .word_idx  (word_idx),
        .hdr_match (hdr_match),
        .hdr_valid (hdr_valid),
        .load_tail (load_tail),
        .pass_beat (pass_beat)
    );

    // Payload realignment to lane 0
    rx_payload_align payload_align0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .load_tail (load_tail),
        .pass_beat (pass_beat),
        .payload   (payload)
    );

endmodule

// ==== src/udp_rx_pkg.sv ====
/*
 * Shared types and constants for the UDP receive path:
 * stream beat and header bundle structs, frame state enum,
 * Ethernet/IPv4/UDP match values and header geometry
 */
package udp_rx_pkg;

    // One 64-bit stream beat, frame byte n sits in lane n mod 8
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        valid;
        logic        last;
    } eth_beat_t;

    // Bundled UDP header, length in the top bits, source IP at the bottom
    typedef struct packed {
        logic [15:0] length;
        logic [15:0] dest_port;
        logic [15:0] source_port;
        logic [31:0] dest_ip;
        logic [31:0] source_ip;
    } udp_hdr_t;

    // Per-frame receive states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_HEADER  = 2'd1,
        ST_PAYLOAD = 2'd2,
        ST_DROP    = 2'd3
    } rx_state_e;

    // Accepted header values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // Beat index width, the index saturates at 7
    localparam int WORD_IDX_W = 3;

    // Ethernet 14 + IPv4 20 + UDP 8
    localparam int HDR_BYTES = 42;

    // Beat that carries the UDP checksum and the first payload bytes
    localparam logic [WORD_IDX_W-1:0] HDR_LAST_WORD = WORD_IDX_W'(HDR_BYTES / 8);

    // Header bytes at the bottom of that beat, also the payload lane shift
    localparam int TAIL_BYTES = HDR_BYTES % 8;

endpackage

// ==== testbench/tb_udp_rx.sv ====
/*
 * Testbench top for the UDP receive core: clock, reset,
 * frame builder with reference model, stimulus sequence
 */
module tb_udp_rx;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [7:0] byte_q_t[$];
    typedef udp_rx_pkg::eth_beat_t beat_q_t[$];

    // Header fields of one test frame
    typedef struct packed {
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  proto;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } frame_cfg_t;

    localparam logic [31:0] LOCAL_IP = 32'hc0a8_0a05;

    logic                  clk;
    logic                  arst_n;
    logic [31:0]           local_ip;
    udp_rx_pkg::eth_beat_t rx;
    udp_rx_pkg::udp_hdr_t  hdr;
    logic                  hdr_valid;
    udp_rx_pkg::eth_beat_t payload;
    integer                seed;

    udp_rx_core dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .local_ip  (local_ip),
        .rx        (rx),
        .hdr       (hdr),
        .hdr_valid (hdr_valid),
        .payload   (payload)
    );

    tb_udp_rx_check check0 (
        .clk       (clk),
        .hdr       (hdr),
        .hdr_valid (hdr_valid),
        .payload   (payload)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic int random_below(input int limit);
        return int'(random_word() % 32'(limit));
    endfunction

    function automatic byte_q_t random_payload(input int len);
        byte_q_t     p;
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = random_word();
            p.push_back(r[7:0]);
        end
        return p;
    endfunction

    // Frame that should pass, with random source address and ports
    function automatic frame_cfg_t good_cfg();
        frame_cfg_t  c;
        logic [31:0] r;
        r = random_word();
        c.ethertype = 16'h0800;
        c.ver_ihl   = 8'h45;
        c.proto     = 8'd17;
        c.src_ip    = {8'd10, 8'd0, r[15:0]};
        c.dst_ip    = LOCAL_IP;
        r = random_word();
        c.src_port  = r[31:16];
        c.dst_port  = r[15:0];
        return c;
    endfunction

    // Reference model: frame bytes, expected header and payload beats
    function automatic bit expect_frame(
        input  frame_cfg_t           cfg,
        input  byte_q_t              pl,
        input  logic [31:0]          own_ip,
        output byte_q_t              frame,
        output udp_rx_pkg::udp_hdr_t exp_hdr,
        output beat_q_t              exp_beats
    );
        logic [8*42-1:0]       head;
        logic [15:0]           udp_len;
        logic [15:0]           ip_len;
        udp_rx_pkg::eth_beat_t beat;
        int                    nbeats;
        udp_len = 16'(8 + pl.size());
        ip_len  = 16'(28 + pl.size());
        // Ethernet II, IPv4 without options, UDP, checksums left at zero
        head = {48'h02_00_00_00_00_01, 48'h02_00_00_00_00_02, cfg.ethertype,
                cfg.ver_ihl, 8'h00, ip_len, 16'h1234, 16'h4000, 8'd64, cfg.proto,
                16'h0000, cfg.src_ip, cfg.dst_ip,
                cfg.src_port, cfg.dst_port, udp_len, 16'h0000};
        frame.delete();
        exp_beats.delete();
        for (int i = 0; i < 42; i++) begin
            frame.push_back(head[8*(41-i) +: 8]);
        end
        foreach (pl[i]) begin
            frame.push_back(pl[i]);
        end
        exp_hdr.length      = udp_len;
        exp_hdr.dest_port   = cfg.dst_port;
        exp_hdr.source_port = cfg.src_port;
        exp_hdr.dest_ip     = cfg.dst_ip;
        exp_hdr.source_ip   = cfg.src_ip;
        // Payload packed from lane 0, eight bytes per beat
        nbeats = (pl.size() + 7) / 8;
        for (int k = 0; k < nbeats; k++) begin
            beat = '0;
            beat.valid = 1'b1;
            beat.last  = (k == nbeats - 1);
            for (int i = 0; i < 8; i++) begin
                if (8*k + i < pl.size()) begin
                    beat.data[8*i +: 8] = pl[8*k + i];
                    beat.keep[i]        = 1'b1;
                end
            end
            exp_beats.push_back(beat);
        end
        return (cfg.ethertype == 16'h0800) && (cfg.ver_ihl == 8'h45)
               && (cfg.proto == 8'd17) && (cfg.dst_ip == own_ip);
    endfunction

    // Drives one frame, with idle cycles in front of a beat at gap_pct percent
    task automatic send_frame(input byte_q_t frame, input int gap_pct);
        int          nbeats;
        int          idle;
        logic [31:0] junk;
        nbeats = (frame.size() + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            idle = 0;
            while (idle < 3 && random_below(100) < gap_pct) begin
                @(negedge clk);
                rx.valid = 1'b0;
                rx.last  = 1'b0;
                idle++;
            end
            @(negedge clk);
            junk = random_word();
            rx.valid = 1'b1;
            rx.last  = (b == nbeats - 1);
            for (int i = 0; i < 8; i++) begin
                if (8*b + i < frame.size()) begin
                    rx.data[8*i +: 8] = frame[8*b + i];
                    rx.keep[i]        = 1'b1;
                end else begin
                    // Lanes past the end carry junk
                    rx.data[8*i +: 8] = junk[7:0] ^ 8'(i);
                    rx.keep[i]        = 1'b0;
                end
            end
        end
        @(negedge clk);
        rx.valid = 1'b0;
        rx.last  = 1'b0;
    endtask

    task automatic run_frame(input frame_cfg_t cfg, input byte_q_t pl, input int gap_pct);
        byte_q_t              frame;
        udp_rx_pkg::udp_hdr_t exp_hdr;
        beat_q_t              exp_beats;
        if (expect_frame(cfg, pl, local_ip, frame, exp_hdr, exp_beats)) begin
            check0.push(exp_hdr, exp_beats);
        end
        send_frame(frame, gap_pct);
    endtask

    // Matching frame cut off before its header is complete
    task automatic run_cut_frame(input int keep_bytes);
        byte_q_t              frame;
        udp_rx_pkg::udp_hdr_t exp_hdr;
        beat_q_t              exp_beats;
        void'(expect_frame(good_cfg(), random_payload(16), local_ip,
                           frame, exp_hdr, exp_beats));
        while (frame.size() > keep_bytes) begin
            void'(frame.pop_back());
        end
        send_frame(frame, 0);
    endtask

    initial begin
        frame_cfg_t cfg;
        frame_cfg_t bad;
        byte_q_t    pl;
        seed     = 87649;
        local_ip = LOCAL_IP;
        rx       = '0;
        arst_n   = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (20) @(negedge clk);
        check0.end_test("idle after reset");

        run_frame(good_cfg(), random_payload(32), 0);
        check0.end_test("single 32-byte frame");

        for (int n = 0; n < 40; n++) begin
            run_frame(good_cfg(), random_payload(random_below(41)), 0);
        end
        check0.end_test("random payload lengths");

        // Each rejected frame is followed by a good one
        for (int k = 0; k < 4; k++) begin
            bad = good_cfg();
            case (k)
                0: bad.dst_ip = LOCAL_IP ^ 32'h0000_0100;
                1: bad.ethertype = 16'h0806;
                2: bad.proto = 8'd6;
                default: bad.ver_ihl = 8'h46;
            endcase
            run_frame(bad, random_payload(random_below(41)), 0);
            run_frame(good_cfg(), random_payload(random_below(41)), 0);
        end
        check0.end_test("rejected headers");

        for (int k = 0; k < 4; k++) begin
            run_cut_frame(14 + random_below(27));
            run_frame(good_cfg(), random_payload(random_below(41)), 0);
        end
        check0.end_test("truncated frames");

        // Same frame without and with gaps
        for (int k = 0; k < 20; k++) begin
            cfg = good_cfg();
            pl  = random_payload(random_below(41));
            run_frame(cfg, pl, 0);
            run_frame(cfg, pl, 35);
        end
        check0.end_test("gaps inside frames");

        check0.report_counts();
        if (check0.error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_udp_rx_check.sv ====
/*
 * Testbench monitor for DUT header pulses and payload beats
 * Queued reference entries, comparison and per-test counts
 */
module tb_udp_rx_check (
    input logic                  clk,
    input udp_rx_pkg::udp_hdr_t  hdr,
    input logic                  hdr_valid,
    input udp_rx_pkg::eth_beat_t payload
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_CYCLES = 200;
    localparam int QUIET_CYCLES = 10;

    udp_rx_pkg::udp_hdr_t  exp_hdr_q[$];
    int                    exp_len_q[$];
    udp_rx_pkg::eth_beat_t exp_beat_q[$];
    udp_rx_pkg::udp_hdr_t  want_hdr;
    logic                  in_frame    = 1'b0;
    int                    beats_left  = 0;
    int                    error_count = 0;
    int                    frame_count = 0;
    int                    test_count  = 0;
    int                    tests_bad   = 0;
    int                    err_base    = 0;
    int                    frame_base  = 0;

    task automatic push(input udp_rx_pkg::udp_hdr_t h, input udp_rx_pkg::eth_beat_t beats[$]);
        exp_hdr_q.push_back(h);
        exp_len_q.push_back(beats.size());
        foreach (beats[i]) begin
            exp_beat_q.push_back(beats[i]);
        end
    endtask

    function automatic void drop_open_frame();
        repeat (beats_left) begin
            void'(exp_beat_q.pop_front());
        end
        beats_left = 0;
        in_frame   = 1'b0;
    endfunction

    function automatic void compare_beat(input udp_rx_pkg::eth_beat_t got,
                                         input udp_rx_pkg::eth_beat_t want);
        if (got.keep !== want.keep || got.last !== want.last) begin
            $display("error %0d ns: payload keep %h last %b, expected keep %h last %b",
                     $time, got.keep, got.last, want.keep, want.last);
            error_count++;
        end
        // Only lanes holding payload bytes matter
        for (int i = 0; i < 8; i++) begin
            if (want.keep[i] && got.data[8*i +: 8] !== want.data[8*i +: 8]) begin
                $display("error %0d ns: payload lane %0d is %h, expected %h",
                         $time, i, got.data[8*i +: 8], want.data[8*i +: 8]);
                error_count++;
            end
        end
    endfunction

    // Registered outputs are sampled on the falling edge
    always @(negedge clk) begin
        if (hdr_valid === 1'b1) begin
            if (in_frame) begin
                $display("new header at %0d ns while %0d payload beats were still missing",
                         $time, beats_left);
                error_count++;
                drop_open_frame();
            end
            if (exp_hdr_q.size() == 0) begin
                $display("unexpected header at %0d ns, no frame was sent that should pass",
                         $time);
                error_count++;
            end else begin
                want_hdr   = exp_hdr_q.pop_front();
                beats_left = exp_len_q.pop_front();
                if (hdr !== want_hdr) begin
                    $display("error %0d ns: header %h, expected %h", $time, hdr, want_hdr);
                    error_count++;
                end
                frame_count++;
                in_frame = (beats_left != 0);
            end
        end
        if (payload.valid === 1'b1) begin
            if (!in_frame) begin
                $display("unexpected payload beat at %0d ns outside any accepted frame", $time);
                error_count++;
            end else begin
                compare_beat(payload, exp_beat_q.pop_front());
                beats_left--;
                in_frame = (beats_left != 0);
            end
        end
    end

    // Waits run on the rising edge opposite the sampling edge
    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while ((exp_hdr_q.size() != 0 || in_frame) && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_hdr_q.size() != 0 || in_frame) begin
            $display("timeout in test %s: %0d frames never arrived within %0d cycles",
                     name, exp_hdr_q.size() + (in_frame ? 1 : 0), DRAIN_CYCLES);
            error_count++;
            drop_open_frame();
            exp_hdr_q.delete();
            exp_len_q.delete();
            exp_beat_q.delete();
        end
        // Window for stray output
        repeat (QUIET_CYCLES) @(posedge clk);
        test_count++;
        if (error_count == err_base) begin
            $display("test %s: ok, %0d frames", name, frame_count - frame_base);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, error_count - err_base);
        end
        err_base   = error_count;
        frame_base = frame_count;
    endtask

    function automatic void report_counts();
        $display("tests run %0d, tests with errors %0d, frames checked %0d, errors %0d",
                 test_count, tests_bad, frame_count, error_count);
    endfunction

endmodule
